// File: source/tc_pkg.sv
/*
 * Traffic class buffer package
 * Word and status types plus the sizing constants shared by the
 * sorter, the class FIFOs and the arbiter
 */

`default_nettype none

package tc_pkg;

    // Sizing
    localparam int NUM_CLASSES       = 4;
    localparam int FIFO_DEPTH        = 6;
    localparam int ALMOST_FULL_LEVEL = 4;
    localparam int CLASS_W           = 2;
    localparam int DATA_W            = 8;

    // Ingress word, class in the top bits
    typedef struct packed {
        logic [CLASS_W-1:0]        tc;
        logic [DATA_W-CLASS_W-1:0] payload;
    } tc_word_t;

    // Per FIFO status, registered from the next occupancy
    typedef struct packed {
        logic empty;
        logic full;
        logic almost_full;
    } tc_status_t;

endpackage

`default_nettype wire

// File: source/tc_fifo_mem.sv
/*
 * Class FIFO storage
 * Register array with a synchronous write port and a registered read port
 */

`timescale 1ns/10ps
`default_nettype none

module tc_fifo_mem
    import tc_pkg::*;
#(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     wr_en,
    input  wire logic [2:0] wr_addr,
    input  wire tc_word_t wr_word,
    input  wire logic     rd_en,
    input  wire logic [2:0] rd_addr,
    output tc_word_t      rd_word
);

    tc_word_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // Read register, loaded only on a pop
    always_ff @(posedge clk) begin
        if (!reset) begin
            rd_word <= '0;
        end else if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: source/tc_fifo.sv
/*
 * Single traffic class FIFO
 * Wrapping pointers, occupancy count and registered empty, full and
 * almost full flags. Writes into a full FIFO are ignored
 */

`timescale 1ns/10ps
`default_nettype none

module tc_fifo
    import tc_pkg::*;
#(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     wr_strobe,
    input  wire tc_word_t wr_word,
    input  wire logic     pop,
    output tc_word_t      rd_word,
    output tc_status_t    status
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    // Address ports are 3 bits wide, enough for depths up to 8
    logic [2:0]       wr_ptr;
    logic [2:0]       rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             wr_ok;
    tc_status_t       status_next;

    tc_fifo_mem #(
        .DEPTH (DEPTH)
    ) mem_i (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_ok),
        .wr_addr (wr_ptr),
        .wr_word (wr_word),
        .rd_en   (pop),
        .rd_addr (rd_ptr),
        .rd_word (rd_word)
    );

    // A write into a full FIFO is dropped here
    assign wr_ok = wr_strobe && !status.full;

    always_comb begin
        count_next = count;
        case ({wr_ok, pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    // Flags follow the occupancy after the edge
    always_comb begin
        status_next.empty       = (count_next == '0);
        status_next.full        = (int'(count_next) == DEPTH);
        status_next.almost_full = (int'(count_next) >= ALMOST_FULL_LEVEL);
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            status <= '{empty: 1'b1, full: 1'b0, almost_full: 1'b0};
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == 3'(DEPTH - 1)) ? 3'd0 : wr_ptr + 3'd1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == 3'(DEPTH - 1)) ? 3'd0 : rd_ptr + 3'd1;
            end
            count  <= count_next;
            status <= status_next;
        end
    end

    // The arbiter must only pop a class that reports data
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!reset)
        pop |-> !status.empty
    ) else $error("pop on an empty class FIFO");

    a_count_bound: assert property (
        @(posedge clk) disable iff (!reset)
        int'(count) <= DEPTH
    ) else $error("FIFO occupancy above depth");

    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (!reset)
        !(status.full && status.empty)
    ) else $error("FIFO flagged full and empty together");

endmodule

`default_nettype wire

// File: source/tc_ingress_sort.sv
/*
 * Ingress class sorter
 * Steers each strobed word to the FIFO of its class and keeps
 * sticky per class overflow flags
 */

`timescale 1ns/10ps
`default_nettype none

module tc_ingress_sort
    import tc_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   in_valid,
    input  wire tc_word_t               in_word,
    input  wire logic [NUM_CLASSES-1:0] full,
    output logic [NUM_CLASSES-1:0]      wr_strobe,
    output tc_word_t                    wr_word,
    output logic [NUM_CLASSES-1:0]      overflow_err
);

    // One strobe bit selected by the class field
    assign wr_strobe = in_valid ? (NUM_CLASSES'(1) << in_word.tc) : '0;

    // Every FIFO sees the same word, only the strobed one stores it
    assign wr_word = in_word;

    // Set when a strobe lands on a full class, cleared by reset only
    always_ff @(posedge clk) begin
        if (!reset) begin
            overflow_err <= '0;
        end else begin
            overflow_err <= overflow_err | (wr_strobe & full);
        end
    end

    a_strobe_onehot: assert property (
        @(posedge clk) disable iff (!reset)
        $onehot0(wr_strobe)
    ) else $error("more than one class write strobe");

endmodule

`default_nettype wire

// File: source/tc_rr_arbiter.sv
/*
 * Round robin egress arbiter
 * Pops one non-empty class per cycle, starting after the last grant,
 * and registers the popped word onto the egress strobe
 */

`timescale 1ns/10ps
`default_nettype none

module tc_rr_arbiter
    import tc_pkg::*;
(
    input  wire logic                               clk,
    input  wire logic                               reset,
    input  wire logic                               egress_hold,
    input  wire logic [NUM_CLASSES-1:0]             empty,
    input  wire tc_word_t [NUM_CLASSES-1:0]         rd_word,
    output logic [NUM_CLASSES-1:0]                  pop,
    output logic                                    out_valid,
    output tc_word_t                                out_word
);

    logic [CLASS_W-1:0] last_grant;
    logic [CLASS_W-1:0] grant_idx;
    logic               grant_valid;
    logic [CLASS_W-1:0] granted_q;
    logic               pop_q;

    // Search the classes after last_grant, wrapping back to it
    always_comb begin
        logic [CLASS_W-1:0] idx;
        grant_valid = 1'b0;
        grant_idx   = last_grant;
        for (int i = 1; i <= NUM_CLASSES; i++) begin
            idx = last_grant + CLASS_W'(i);
            if (!grant_valid && !empty[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = idx;
            end
        end
    end

    assign pop = (grant_valid && !egress_hold) ? (NUM_CLASSES'(1) << grant_idx) : '0;

    // Pointer starts at class 3 so class 0 wins first
    always_ff @(posedge clk) begin
        if (!reset) begin
            last_grant <= CLASS_W'(NUM_CLASSES - 1);
            pop_q      <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            if (|pop) begin
                last_grant <= grant_idx;
            end
            pop_q     <= |pop;
            out_valid <= pop_q;
        end
    end

    // FIFO read register is loaded at the pop edge, take it one cycle later
    always_ff @(posedge clk) begin
        if (|pop) begin
            granted_q <= grant_idx;
        end
        if (pop_q) begin
            out_word <= rd_word[granted_q];
        end
    end

    a_pop_onehot: assert property (
        @(posedge clk) disable iff (!reset)
        $onehot0(pop)
    ) else $error("more than one class popped");

    a_hold_stalls: assert property (
        @(posedge clk) disable iff (!reset)
        egress_hold |-> (pop == '0)
    ) else $error("pop while egress is held");

endmodule

`default_nettype wire

// File: source/tc_buffer_top.sv
/*
 * Four class transaction buffer
 * Ingress sorter, one FIFO per traffic class and a round robin
 * arbiter onto a single egress strobe
 */

`timescale 1ns/10ps
`default_nettype none

module tc_buffer_top
    import tc_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               in_valid,
    input  wire tc_word_t           in_word,
    input  wire logic               egress_hold,
    output logic                    out_valid,
    output tc_word_t                out_word,
    output logic [NUM_CLASSES-1:0]  pause,
    output logic [NUM_CLASSES-1:0]  empty,
    output logic [NUM_CLASSES-1:0]  overflow_err
);

    logic [NUM_CLASSES-1:0]       wr_strobe;
    tc_word_t                     wr_word;
    logic [NUM_CLASSES-1:0]       full;
    logic [NUM_CLASSES-1:0]       pop;
    tc_word_t [NUM_CLASSES-1:0]   rd_word;
    tc_status_t [NUM_CLASSES-1:0] status;

    tc_ingress_sort sort_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_word      (in_word),
        .full         (full),
        .wr_strobe    (wr_strobe),
        .wr_word      (wr_word),
        .overflow_err (overflow_err)
    );

    // One FIFO per class, flags split out to the ports
    for (genvar g = 0; g < NUM_CLASSES; g++) begin : g_class
        tc_fifo #(
            .DEPTH (FIFO_DEPTH)
        ) fifo_i (
            .clk       (clk),
            .reset     (reset),
            .wr_strobe (wr_strobe[g]),
            .wr_word   (wr_word),
            .pop       (pop[g]),
            .rd_word   (rd_word[g]),
            .status    (status[g])
        );

        assign full[g]  = status[g].full;
        assign empty[g] = status[g].empty;
        assign pause[g] = status[g].almost_full;
    end

    tc_rr_arbiter arb_i (
        .clk         (clk),
        .reset       (reset),
        .egress_hold (egress_hold),
        .empty       (empty),
        .rd_word     (rd_word),
        .pop         (pop),
        .out_valid   (out_valid),
        .out_word    (out_word)
    );

endmodule

`default_nettype wire

// File: test/tc_buffer_checker.sv
/*
 * Traffic class buffer checker
 * Cycle model of the class queues, flags and egress pipeline,
 * compared against the DUT ports on every rising edge
 */

`timescale 1ns/10ps
`default_nettype none

module tc_buffer_checker
    import tc_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   in_valid,
    input  wire tc_word_t               in_word,
    input  wire logic                   egress_hold,
    input  wire logic                   out_valid,
    input  wire tc_word_t               out_word,
    input  wire logic [NUM_CLASSES-1:0] pause,
    input  wire logic [NUM_CLASSES-1:0] empty,
    input  wire logic [NUM_CLASSES-1:0] overflow_err,
    output int                          error_count,
    output int                          check_count
);

    // Model queues kept as circular buffers
    tc_word_t               q_mem [NUM_CLASSES][FIFO_DEPTH];
    int                     q_head [NUM_CLASSES];
    int                     q_cnt [NUM_CLASSES];
    logic [NUM_CLASSES-1:0] m_err;
    int                     m_last;
    logic                   m_pop_v;
    tc_word_t               m_pop_w;
    logic                   m_out_v;
    tc_word_t               m_out_w;
    logic                   armed;

    initial begin
        error_count = 0;
        check_count = 0;
        armed       = 1'b0;
    end

    task automatic check_flag(input string what, input int cls, input logic got,
                              input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t: %s of class %0d is %b, expected %b",
                     $time, what, cls, got, exp);
        end
    endtask

    task automatic compare_outputs();
        for (int c = 0; c < NUM_CLASSES; c++) begin
            check_flag("empty", c, empty[c], q_cnt[c] == 0);
            check_flag("pause", c, pause[c], q_cnt[c] >= ALMOST_FULL_LEVEL);
            check_flag("overflow_err", c, overflow_err[c], m_err[c]);
        end
        check_count++;
        if (out_valid !== m_out_v) begin
            error_count++;
            $display("ERROR %0t: out_valid is %b, expected %b", $time, out_valid, m_out_v);
        end else if (m_out_v) begin
            check_count++;
            if (out_word !== m_out_w) begin
                error_count++;
                $display("ERROR %0t: out_word is %h, expected %h", $time, out_word, m_out_w);
            end
        end
    endtask

    task automatic reset_model();
        for (int c = 0; c < NUM_CLASSES; c++) begin
            q_head[c] = 0;
            q_cnt[c]  = 0;
        end
        m_err   = '0;
        m_last  = NUM_CLASSES - 1;
        m_pop_v = 1'b0;
        m_out_v = 1'b0;
    endtask

    task automatic step_model();
        logic [NUM_CLASSES-1:0] full_pre;
        logic                   popped;
        tc_word_t               pw;
        int                     g;
        int                     c;
        int                     tail;
        for (int k = 0; k < NUM_CLASSES; k++) begin
            full_pre[k] = (q_cnt[k] == FIFO_DEPTH);
        end
        popped = 1'b0;
        pw     = '0;
        // Next non-empty class after the last grant
        if (!egress_hold) begin
            for (int i = 1; i <= NUM_CLASSES; i++) begin
                g = (m_last + i) % NUM_CLASSES;
                if (!popped && q_cnt[g] > 0) begin
                    popped    = 1'b1;
                    pw        = q_mem[g][q_head[g]];
                    q_head[g] = (q_head[g] + 1) % FIFO_DEPTH;
                    q_cnt[g]--;
                    m_last    = g;
                end
            end
        end
        if (in_valid) begin
            c = in_word.tc;
            if (full_pre[c]) begin
                m_err[c] = 1'b1;
            end else begin
                tail           = (q_head[c] + q_cnt[c]) % FIFO_DEPTH;
                q_mem[c][tail] = in_word;
                q_cnt[c]++;
            end
        end
        // Pop edge, then one more edge to the egress register
        m_out_v = m_pop_v;
        m_out_w = m_pop_w;
        m_pop_v = popped;
        m_pop_w = pw;
    endtask

    always @(posedge clk) begin
        if (armed) begin
            compare_outputs();
        end
        if (!reset) begin
            reset_model();
            armed = 1'b1;
        end else if (armed) begin
            step_model();
        end
    end

endmodule

`default_nettype wire

// File: test/tc_buffer_tb.sv
/*
 * Traffic class buffer testbench
 * Random traffic from an LCG through reset, order, flag, overflow,
 * round robin and hold tests, checked by tc_buffer_checker
 */

`timescale 1ns/10ps
`default_nettype none

module tc_buffer_tb
    import tc_pkg::*;
();

    localparam int          CLK_PERIOD = 10;
    localparam int          RESET_LEN  = 8;
    localparam int          ORDER_LEN  = 400;
    localparam int          HOLD_LEN   = 300;
    localparam int          DRAIN_MAX  = 64;
    localparam int          NUM_TESTS  = 6;
    localparam logic [31:0] SEED       = 32'h7a0;
    // Summed test lengths plus margin
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (RESET_LEN + DRAIN_MAX + 40)
                                     + ORDER_LEN + HOLD_LEN + 500;

    logic                   clk;
    logic                   reset;
    logic                   in_valid;
    tc_word_t               in_word;
    logic                   egress_hold;
    logic                   out_valid;
    tc_word_t               out_word;
    logic [NUM_CLASSES-1:0] pause;
    logic [NUM_CLASSES-1:0] empty;
    logic [NUM_CLASSES-1:0] overflow_err;
    int                     chk_errors;
    int                     chk_checks;
    logic [31:0]            rng_state;
    int                     tests_failed;
    int                     drain_fail;
    int                     err_base;

    tc_buffer_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_word      (in_word),
        .egress_hold  (egress_hold),
        .out_valid    (out_valid),
        .out_word     (out_word),
        .pause        (pause),
        .empty        (empty),
        .overflow_err (overflow_err)
    );

    tc_buffer_checker checker_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_word      (in_word),
        .egress_hold  (egress_hold),
        .out_valid    (out_valid),
        .out_word     (out_word),
        .pause        (pause),
        .empty        (empty),
        .overflow_err (overflow_err),
        .error_count  (chk_errors),
        .check_count  (chk_checks)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic tc_word_t class_word(input logic [CLASS_W-1:0] cls,
                                            input logic [31:0] r);
        tc_word_t w;
        w.tc      = cls;
        w.payload = r[DATA_W-CLASS_W-1:0];
        return w;
    endfunction

    task automatic drive(input logic v, input tc_word_t w, input logic hold);
        @(posedge clk);
        in_valid    <= v;
        in_word     <= w;
        egress_hold <= hold;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset       <= 1'b0;
        in_valid    <= 1'b0;
        egress_hold <= 1'b0;
        repeat (RESET_LEN) @(posedge clk);
        reset <= 1'b1;
    endtask

    // Release hold and wait for every class to empty
    task automatic drain();
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done && n < DRAIN_MAX) begin
            drive(1'b0, '0, 1'b0);
            @(negedge clk);
            done = &empty;
            n++;
        end
        if (!done) begin
            drain_fail++;
            $display("Drain timed out at %0t: class FIFOs still hold data", $time);
        end
        // Words still in flight to the egress register
        repeat (3) drive(1'b0, '0, 1'b0);
    endtask

    task automatic end_test(input string name);
        int errs;
        @(negedge clk);
        errs = chk_errors + drain_fail - err_base;
        if (errs == 0) begin
            $display("test %-12s passed", name);
        end else begin
            tests_failed++;
            $display("test %-12s failed with %0d errors", name, errs);
        end
        err_base = chk_errors + drain_fail;
    endtask

    initial begin
        logic [31:0] r;
        logic        hold;
        rng_state    = SEED;
        tests_failed = 0;
        drain_fail   = 0;
        err_base     = 0;
        reset        = 1'b0;
        in_valid     = 1'b0;
        in_word      = '0;
        egress_hold  = 1'b0;
        repeat (RESET_LEN) @(posedge clk);
        reset <= 1'b1;

        repeat (4) drive(1'b0, '0, 1'b0);
        end_test("reset");

        for (int i = 0; i < ORDER_LEN; i++) begin
            r = next_random();
            drive(r[31:30] != 2'b00, tc_word_t'(r[15:8]), 1'b0);
        end
        drain();
        end_test("order");

        // Spaced writes to class 1 so each flag step is seen
        apply_reset();
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            drive(1'b1, class_word(2'd1, next_random()), 1'b1);
            drive(1'b0, '0, 1'b1);
        end
        repeat (3) drive(1'b0, '0, 1'b1);
        drain();
        end_test("flags");

        apply_reset();
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            drive(1'b1, class_word(2'd2, next_random()), 1'b1);
        end
        repeat (3) drive(1'b0, '0, 1'b1);
        drain();
        end_test("overflow");

        // Uneven fill so short classes drop out of the rotation
        apply_reset();
        for (int c = 0; c < NUM_CLASSES; c++) begin
            r = next_random();
            for (int n = 0; n <= int'(r[7:0]) % FIFO_DEPTH; n++) begin
                drive(1'b1, class_word(CLASS_W'(c), next_random()), 1'b1);
            end
        end
        repeat (2) drive(1'b0, '0, 1'b1);
        drain();
        end_test("round_robin");

        apply_reset();
        hold = 1'b0;
        for (int i = 0; i < HOLD_LEN; i++) begin
            r = next_random();
            if (r[7:4] == 4'h0) begin
                hold = ~hold;
            end
            drive(r[31], tc_word_t'(r[23:16]), hold);
        end
        drain();
        end_test("hold");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS, tests_failed, chk_checks, chk_errors + drain_fail);
        if (tests_failed == 0 && chk_errors + drain_fail == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the test sequence did not finish",
                 WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
source/tc_pkg.sv
source/tc_fifo_mem.sv
source/tc_fifo.sv
source/tc_ingress_sort.sv
source/tc_rr_arbiter.sv
source/tc_buffer_top.sv
test/tc_buffer_checker.sv
test/tc_buffer_tb.sv
